//--- src/fetch_pkg.sv
/*
  Fetch stage package
  Sizes, instruction opcodes, the redirect encoding and the structs passed
  between prefetcher, word FIFO, aligner and the IF/ID pipeline register
*/

package fetch_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  // Fetched words held in the buffer, also the prefetcher credit limit
  localparam int FIFO_DEPTH = 4;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  // Counters must reach FIFO_DEPTH itself
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  // Word address width on the instruction memory port
  localparam int WADDR_W    = 30;

  // 32-bit opcodes produced by the compressed expansion
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  ////////////////////////////////////////
  // Redirect
  ////////////////////////////////////////

  // Source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_TRAP_EXC = 3'd2,
    PC_TRAP_IRQ = 3'd3,
    PC_MRET     = 3'd4
  } pc_mux_e;

  // Redirect command from the controller
  typedef struct packed {
    logic       valid;
    pc_mux_e    pc_mux;
    logic [4:0] irq_idx;    // vector index for PC_TRAP_IRQ
  } redirect_t;

  ////////////////////////////////////////
  // Datapath payloads
  ////////////////////////////////////////

  // One fetched word tagged with its word address
  typedef struct packed {
    logic [WADDR_W-1:0] addr;
    logic [31:0]        rdata;
  } fetch_word_t;

  // IF/ID pipeline register, its valid travels beside it
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;               // expanded instruction
    logic [15:0] compressed_instr;    // original low halfword
    logic        compressed;
    logic        illegal_c;
  } if_id_t;

endpackage

//--- src/fetch_c_decoder.sv
/*
  Compressed instruction expander
  Turns C.ADDI, C.LI, C.J and C.MV into 32-bit form, flags the rest
*/

`timescale 1ns/1ps

module fetch_c_decoder (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  import fetch_pkg::*;

  logic [15:0] c;

  // Only the low halfword matters for a compressed encoding
  assign c               = instr_i[15:0];
  assign is_compressed_o = (c[1:0] != 2'b11);

  always_comb begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    if (is_compressed_o) begin
      // Outside the subset the halfword passes through as illegal
      illegal_o = 1'b1;

      // funct3 and quadrant select the encoding
      case ({c[15:13], c[1:0]})

        5'b000_01: begin
          // C.ADDI -> addi rd, rd, sext(imm6)
          instr_o   = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], OPC_OP_IMM};
          illegal_o = 1'b0;
        end

        5'b010_01: begin
          // C.LI -> addi rd, x0, sext(imm6)
          instr_o   = {{6{c[12]}}, c[12], c[6:2], 5'b00000, 3'b000, c[11:7], OPC_OP_IMM};
          illegal_o = 1'b0;
        end

        5'b101_01: begin
          // C.J -> jal x0, offset
          // Offset bits are scattered over the halfword
          instr_o   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                       c[12], {8{c[12]}}, 5'b00000, OPC_JAL};
          illegal_o = 1'b0;
        end

        5'b100_10: begin
          // C.MV -> add rd, x0, rs2
          // rs2 of zero is C.JR and bit 12 set is C.ADD, both outside the subset
          if (!c[12] && (c[6:2] != 5'b00000)) begin
            instr_o   = {7'b0000000, c[6:2], 5'b00000, 3'b000, c[11:7], OPC_OP};
            illegal_o = 1'b0;
          end
        end

        default: begin
          instr_o = instr_i;
        end

      endcase
    end
  end

endmodule

//--- src/fetch_prefetcher.sv
/*
  Fetch prefetcher
  Picks the redirect target, issues word requests under a credit limit,
  tags in-order responses with their address and drops stale ones
*/

`timescale 1ns/1ps

module fetch_prefetcher (
  input  logic                            clk,
  input  logic                            rst_n,
  input  fetch_pkg::redirect_t            redirect_i,
  input  logic [31:0]                     boot_addr_i,
  input  logic [31:0]                     jump_target_i,
  input  logic [31:0]                     mepc_i,
  input  logic [23:0]                     mtvec_i,
  output logic                            req_valid_o,
  input  logic                            req_ready_i,
  output logic [fetch_pkg::WADDR_W-1:0]   req_addr_o,
  input  logic                            rsp_valid_i,
  input  logic [31:0]                     rsp_rdata_i,
  input  logic                            pop_i,
  output logic                            push_valid_o,
  output fetch_pkg::fetch_word_t          push_word_o,
  output logic [31:0]                     start_pc_o,
  output logic                            busy_o
);

  import fetch_pkg::*;

  logic [31:0]        target_pc;
  logic               active_q;
  logic [WADDR_W-1:0] fetch_addr_q;
  logic               req_fire;
  logic               rsp_drop;

  logic [CNT_W-1:0]   outstanding_q;
  logic [CNT_W-1:0]   outstanding_d;
  logic [CNT_W-1:0]   drop_q;
  logic [CNT_W-1:0]   drop_d;
  logic [CNT_W-1:0]   credit_q;
  logic [CNT_W-1:0]   credit_d;

  // In-order queue of request addresses
  logic [WADDR_W-1:0] aq_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]   aq_wr_q;
  logic [PTR_W-1:0]   aq_rd_q;

  ////////////////////////////////////////
  // Target selection
  ////////////////////////////////////////

  always_comb begin
    case (redirect_i.pc_mux)
      PC_BOOT:     target_pc = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     target_pc = {jump_target_i[31:1], 1'b0};
      // All exceptions share the trap base
      PC_TRAP_EXC: target_pc = {mtvec_i, 8'h00};
      // Interrupts are vectored on the index
      PC_TRAP_IRQ: target_pc = {mtvec_i, 1'b0, redirect_i.irq_idx, 2'b00};
      PC_MRET:     target_pc = {mepc_i[31:1], 1'b0};
      default:     target_pc = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  // Aligner starts from the halfword of the target
  assign start_pc_o = target_pc;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Credit only rises while stalled, so valid holds until accepted
  assign req_valid_o = active_q & (credit_q != '0);
  assign req_addr_o  = fetch_addr_q;
  assign req_fire    = req_valid_o & req_ready_i;
  assign busy_o      = (outstanding_q != '0);

  // Oldest responses belong to requests from before the last redirect
  assign rsp_drop     = rsp_valid_i & (drop_q != '0);
  assign push_valid_o = rsp_valid_i & (drop_q == '0);
  assign push_word_o  = '{addr: aq_mem[aq_rd_q], rdata: rsp_rdata_i};

  always_comb begin
    outstanding_d = outstanding_q + CNT_W'(req_fire) - CNT_W'(rsp_valid_i);
    if (redirect_i.valid) begin
      // Everything still in flight becomes stale
      drop_d   = outstanding_d;
      // Stale requests keep their credit until their response is dropped
      credit_d = CNT_W'(FIFO_DEPTH) - outstanding_d;
    end else begin
      drop_d   = drop_q - CNT_W'(rsp_drop);
      credit_d = credit_q - CNT_W'(req_fire) + CNT_W'(pop_i) + CNT_W'(rsp_drop);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q      <= 1'b0;
      fetch_addr_q  <= '0;
      outstanding_q <= '0;
      drop_q        <= '0;
      credit_q      <= CNT_W'(FIFO_DEPTH);
      aq_wr_q       <= '0;
      aq_rd_q       <= '0;
    end else begin
      outstanding_q <= outstanding_d;
      drop_q        <= drop_d;
      credit_q      <= credit_d;
      aq_wr_q       <= aq_wr_q + PTR_W'(req_fire);
      aq_rd_q       <= aq_rd_q + PTR_W'(rsp_valid_i);
      if (redirect_i.valid) begin
        active_q     <= 1'b1;
        fetch_addr_q <= target_pc[31:2];
      end else if (!active_q) begin
        // Idle fetch address follows the boot address
        fetch_addr_q <= boot_addr_i[31:2];
      end else if (req_fire) begin
        fetch_addr_q <= fetch_addr_q + WADDR_W'(1);
      end
    end
  end

  // Address of each accepted request, read back with its response
  always_ff @(posedge clk) begin
    if (req_fire) begin
      aq_mem[aq_wr_q] <= fetch_addr_q;
    end
  end

endmodule

//--- src/fetch_word_fifo.sv
/*
  Fetched word FIFO
  Circular buffer between prefetcher and aligner, flushed on redirect
*/

`timescale 1ns/1ps

module fetch_word_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   push_valid_i,
  input  fetch_pkg::fetch_word_t push_word_i,
  output logic                   word_valid_o,
  output fetch_pkg::fetch_word_t word_o,
  input  logic                   word_ready_i
);

  import fetch_pkg::*;

  fetch_word_t      mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // Head entry shows one cycle after its push
  assign word_valid_o = (count_q != '0);
  assign word_o       = mem[rd_ptr_q];
  assign pop          = word_valid_o & word_ready_i;

  ////////////////////////////////////////
  // Pointers and occupancy
  ////////////////////////////////////////

  // No full check, the prefetcher credit keeps pushes within depth
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // Whole buffer is emptied in one edge
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(push_valid_i);
      rd_ptr_q <= rd_ptr_q + PTR_W'(pop);
      count_q  <= count_q + CNT_W'(push_valid_i) - CNT_W'(pop);
    end
  end

  ////////////////////////////////////////
  // Storage
  ////////////////////////////////////////

  // A write during flush lands behind the reset pointers and is never read
  always_ff @(posedge clk) begin
    if (push_valid_i) begin
      mem[wr_ptr_q] <= push_word_i;
    end
  end

endmodule

//--- src/fetch_aligner.sv
/*
  Fetch aligner
  Cuts halfword-aligned instructions out of the word stream, joins
  straddling 32-bit instructions and drives the IF/ID register
*/

`timescale 1ns/1ps

module fetch_aligner (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic [31:0]            start_pc_i,
  input  logic                   word_valid_i,
  input  fetch_pkg::fetch_word_t word_i,
  output logic                   word_ready_o,
  output logic                   if_id_valid_o,
  output fetch_pkg::if_id_t      if_id_o,
  input  logic                   id_ready_i
);

  import fetch_pkg::*;

  // pc_q[1] also says which half of the head word comes next
  logic [31:0] pc_q;
  logic        res_valid_q;
  logic [15:0] res_q;
  logic        if_id_valid_q;
  if_id_t      if_id_q;

  logic [15:0] half_sel;
  logic [31:0] instr_raw;
  logic        instr_avail;
  logic        consume;
  logic        res_load;
  logic        load_en;
  logic        emit;

  logic [31:0] dec_instr;
  logic        dec_compressed;
  logic        dec_illegal;

  ////////////////////////////////////////
  // Instruction assembly
  ////////////////////////////////////////

  always_comb begin
    half_sel    = pc_q[1] ? word_i.rdata[31:16] : word_i.rdata[15:0];
    instr_raw   = word_i.rdata;
    instr_avail = 1'b0;
    consume     = 1'b0;
    res_load    = 1'b0;
    if (res_valid_q) begin
      // Straddling instruction completes with the low half of the next word
      instr_raw   = {word_i.rdata[15:0], res_q};
      instr_avail = word_valid_i;
    end else if (half_sel[1:0] != 2'b11) begin
      // Compressed, word leaves once its upper half is used
      instr_raw   = {16'h0000, half_sel};
      instr_avail = word_valid_i;
      consume     = pc_q[1];
    end else if (pc_q[1]) begin
      // 32-bit start in the upper half, park it and wait for the next word
      res_load    = word_valid_i;
    end else begin
      // Aligned 32-bit instruction takes the whole word
      instr_avail = word_valid_i;
      consume     = 1'b1;
    end
  end

  // Register takes a new entry when empty or when ID accepts the current one
  assign load_en      = ~if_id_valid_q | id_ready_i;
  assign emit         = instr_avail & load_en;
  assign word_ready_o = (emit & consume) | res_load;

  fetch_c_decoder i_c_decoder (
    .instr_i         (instr_raw),
    .instr_o         (dec_instr),
    .is_compressed_o (dec_compressed),
    .illegal_o       (dec_illegal)
  );

  ////////////////////////////////////////
  // PC, residue and IF/ID valid
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q          <= '0;
      res_valid_q   <= 1'b0;
      if_id_valid_q <= 1'b0;
    end else if (flush_i) begin
      // Restart at the redirect target, offset 2 skips the low half
      pc_q          <= start_pc_i;
      res_valid_q   <= 1'b0;
      if_id_valid_q <= 1'b0;
    end else begin
      if (res_load) begin
        res_valid_q <= 1'b1;
      end else if (emit) begin
        res_valid_q <= 1'b0;
      end
      if (emit) begin
        pc_q          <= pc_q + (dec_compressed ? 32'd2 : 32'd4);
        if_id_valid_q <= 1'b1;
      end else if (id_ready_i) begin
        if_id_valid_q <= 1'b0;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (res_load) begin
      res_q <= half_sel;
    end
    if (emit) begin
      if_id_q.pc               <= pc_q;
      if_id_q.instr            <= dec_instr;
      if_id_q.compressed_instr <= instr_raw[15:0];
      if_id_q.compressed       <= dec_compressed;
      if_id_q.illegal_c        <= dec_illegal;
    end
  end

  assign if_id_valid_o = if_id_valid_q;
  assign if_id_o       = if_id_q;

endmodule

//--- src/fetch_stage.sv
/*
  Instruction fetch stage top
  Prefetcher feeds the word FIFO, the aligner drains it into IF/ID
*/

`timescale 1ns/1ps

module fetch_stage (
  input  logic                          clk,
  input  logic                          rst_n,
  input  fetch_pkg::redirect_t          redirect_i,
  input  logic [31:0]                   boot_addr_i,
  input  logic [31:0]                   jump_target_i,
  input  logic [31:0]                   mepc_i,
  input  logic [23:0]                   mtvec_i,
  input  logic                          id_ready_i,
  input  logic                          req_ready_i,
  input  logic                          rsp_valid_i,
  input  logic [31:0]                   rsp_rdata_i,
  output logic                          req_valid_o,
  output logic [fetch_pkg::WADDR_W-1:0] req_addr_o,
  output logic                          if_id_valid_o,
  output fetch_pkg::if_id_t             if_id_o,
  output logic                          busy_o
);

  import fetch_pkg::*;

  // Prefetcher to FIFO
  logic        push_valid;
  fetch_word_t push_word;
  // FIFO to aligner
  logic        word_valid;
  fetch_word_t word;
  logic        word_ready;
  // Redirect target for the aligner
  logic [31:0] start_pc;

  ////////////////////////////////////////
  // Producer
  ////////////////////////////////////////

  // word_ready already includes word_valid, so it doubles as the pop
  fetch_prefetcher i_prefetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .boot_addr_i   (boot_addr_i),
    .jump_target_i (jump_target_i),
    .mepc_i        (mepc_i),
    .mtvec_i       (mtvec_i),
    .req_valid_o   (req_valid_o),
    .req_ready_i   (req_ready_i),
    .req_addr_o    (req_addr_o),
    .rsp_valid_i   (rsp_valid_i),
    .rsp_rdata_i   (rsp_rdata_i),
    .pop_i         (word_ready),
    .push_valid_o  (push_valid),
    .push_word_o   (push_word),
    .start_pc_o    (start_pc),
    .busy_o        (busy_o)
  );

  ////////////////////////////////////////
  // Buffer and consumer
  ////////////////////////////////////////

  fetch_word_fifo i_word_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i.valid),
    .push_valid_i (push_valid),
    .push_word_i  (push_word),
    .word_valid_o (word_valid),
    .word_o       (word),
    .word_ready_i (word_ready)
  );

  fetch_aligner i_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (redirect_i.valid),
    .start_pc_i    (start_pc),
    .word_valid_i  (word_valid),
    .word_i        (word),
    .word_ready_o  (word_ready),
    .if_id_valid_o (if_id_valid_o),
    .if_id_o       (if_id_o),
    .id_ready_i    (id_ready_i)
  );

endmodule

//--- testbench/fetch_chk.sv
/*
  Fetch stage checker
  Handshake, reset and request limit assertions, bound to the top level
*/

`timescale 1ns/1ps

module fetch_chk (
  input logic                          clk,
  input logic                          rst_n,
  input fetch_pkg::redirect_t          redirect_i,
  input logic                          req_valid_o,
  input logic                          req_ready_i,
  input logic [fetch_pkg::WADDR_W-1:0] req_addr_o,
  input logic                          rsp_valid_i,
  input logic                          if_id_valid_o,
  input fetch_pkg::if_id_t             if_id_o,
  input logic                          id_ready_i
);

  import fetch_pkg::*;

  int outstanding;

  // Requests accepted but not yet answered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(req_valid_o && req_ready_i) - int'(rsp_valid_i);
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  a_reset_idle : assert property (@(posedge clk)
    $rose(rst_n) |-> (!req_valid_o && !if_id_valid_o))
    else $error("request or IF/ID valid high right after reset");

  // Stalled request keeps its address unless redirected
  a_req_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid_o && !req_ready_i && !redirect_i.valid) |=> (req_valid_o && $stable(req_addr_o)))
    else $error("stalled request changed");

  a_if_id_stable : assert property (@(posedge clk) disable iff (!rst_n)
    (if_id_valid_o && !id_ready_i && !redirect_i.valid) |=> (if_id_valid_o && $stable(if_id_o)))
    else $error("IF/ID register changed under back-pressure");

  a_credit_limit : assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= FIFO_DEPTH)
    else $error("more requests outstanding than FIFO entries");

endmodule

bind fetch_stage fetch_chk i_chk (.*);

//--- testbench/tb_fetch_stage.sv
/*
  Fetch stage testbench
  Memory model with random delay, a redirect table with expected IF/ID
  entries, random ID stalls and a cycle limit
*/

`timescale 1ns/1ps

module tb_fetch_stage;

  import fetch_pkg::*;

  localparam int          NUM_ROWS       = 5;
  localparam int          NUM_EXP        = 23;
  localparam int          TIMEOUT_CYCLES = 200 * NUM_ROWS;
  // Program image lives at byte 0x100, word address 64
  localparam logic [23:0] IMAGE_WBLOCK   = 24'd1;

  // One redirect with the number of IF/ID entries that follow it
  typedef struct packed {
    pc_mux_e     kind;
    logic [31:0] target;
    logic [4:0]  irq_idx;
    logic [7:0]  count;
  } row_t;

  // Expected IF/ID entry
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
    logic        illegal;
  } exp_t;

  // Outstanding memory request
  typedef struct packed {
    logic [WADDR_W-1:0] addr;
    logic [31:0]        due;
  } mem_req_t;

  logic                clk = 1'b0;
  logic                rst_n;
  redirect_t           redirect_i;
  logic [31:0]         boot_addr_i;
  logic [31:0]         jump_target_i;
  logic [31:0]         mepc_i;
  logic [23:0]         mtvec_i;
  logic                id_ready_i;
  logic                req_ready_i;
  logic                rsp_valid_i;
  logic [31:0]         rsp_rdata_i;
  logic                req_valid_o;
  logic [WADDR_W-1:0]  req_addr_o;
  logic                if_id_valid_o;
  if_id_t              if_id_o;
  logic                busy_o;

  logic [31:0] image [64];
  row_t        rows [NUM_ROWS];
  exp_t        exp_tab [NUM_EXP];
  mem_req_t    pending [$];
  logic [31:0] cycles = '0;
  logic [31:0] lcg_state = 32'd22625;

  fetch_stage i_dut (.*);

  always #4 clk = ~clk;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  function automatic logic [31:0] rand_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Words outside the image read back as their own address
  function automatic logic [31:0] mem_read(logic [WADDR_W-1:0] addr);
    if (addr[29:6] == IMAGE_WBLOCK) begin
      return image[addr[5:0]];
    end
    return {addr, 2'b11};
  endfunction

  // Original halfword at a PC inside the image
  function automatic logic [15:0] half_at(logic [31:0] pc);
    logic [31:0] w;
    w = image[pc[7:2]];
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic fail_run(string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(string field, logic [31:0] got, logic [31:0] exp);
    fail_run($sformatf("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                       $time, field, got, exp));
  endtask

  task automatic load_tables();
    for (int i = 0; i < 64; i++) begin
      image[i] = {IMAGE_WBLOCK, i[5:0], 2'b11};
    end
    // EXC at 0x100, illegal C.LW, C.JR and C.ADD around a 32-bit word
    image[0]  = 32'h8082_4188;
    image[1]  = 32'h0070_0393;
    image[2]  = 32'h908A_419D;
    // IRQ vector 8 at 0x120, straddle at 0x126
    image[8]  = 32'h0080_0413;
    image[9]  = 32'h0493_8216;
    image[10] = 32'h0095_7FF0;
    // Jump target 0x142, low half skipped
    image[16] = 32'h0095_0001;
    image[17] = 32'h0293_419D;
    image[18] = 32'h8216_1230;
    image[19] = 32'h0060_0313;
    image[20] = 32'h117D_A021;
    // MRET target 0x160
    image[24] = 32'h419D_A021;
    image[25] = 32'h00A0_0513;
    // Boot at 0x180, plain 32-bit code
    image[32] = 32'h0010_0093;
    image[33] = 32'h0020_0113;
    image[34] = 32'h0030_0193;
    image[35] = 32'h0040_0213;

    rows[0] = '{PC_BOOT,     32'h0000_0183, 5'd0, 8'd4};
    rows[1] = '{PC_JUMP,     32'h0000_0143, 5'd0, 8'd7};
    rows[2] = '{PC_TRAP_EXC, 32'h0000_0001, 5'd0, 8'd5};
    rows[3] = '{PC_TRAP_IRQ, 32'h0000_0001, 5'd8, 8'd4};
    rows[4] = '{PC_MRET,     32'h0000_0161, 5'd0, 8'd3};

    exp_tab[0]  = '{32'h180, 32'h0010_0093, 1'b0, 1'b0};
    exp_tab[1]  = '{32'h184, 32'h0020_0113, 1'b0, 1'b0};
    exp_tab[2]  = '{32'h188, 32'h0030_0193, 1'b0, 1'b0};
    exp_tab[3]  = '{32'h18C, 32'h0040_0213, 1'b0, 1'b0};
    exp_tab[4]  = '{32'h142, 32'h0050_8093, 1'b1, 1'b0};  // c.addi x1, 5
    exp_tab[5]  = '{32'h144, 32'h0070_0193, 1'b1, 1'b0};  // c.li x3, 7
    exp_tab[6]  = '{32'h146, 32'h1230_0293, 1'b0, 1'b0};
    exp_tab[7]  = '{32'h14A, 32'h0050_0233, 1'b1, 1'b0};  // c.mv x4, x5
    exp_tab[8]  = '{32'h14C, 32'h0060_0313, 1'b0, 1'b0};
    exp_tab[9]  = '{32'h150, 32'h0080_006F, 1'b1, 1'b0};  // c.j +8
    exp_tab[10] = '{32'h152, 32'hFFF1_0113, 1'b1, 1'b0};  // c.addi x2, -1
    exp_tab[11] = '{32'h100, 32'h0000_4188, 1'b1, 1'b1};
    exp_tab[12] = '{32'h102, 32'h0000_8082, 1'b1, 1'b1};
    exp_tab[13] = '{32'h104, 32'h0070_0393, 1'b0, 1'b0};
    exp_tab[14] = '{32'h108, 32'h0070_0193, 1'b1, 1'b0};
    exp_tab[15] = '{32'h10A, 32'h0000_908A, 1'b1, 1'b1};
    exp_tab[16] = '{32'h120, 32'h0080_0413, 1'b0, 1'b0};
    exp_tab[17] = '{32'h124, 32'h0050_0233, 1'b1, 1'b0};
    exp_tab[18] = '{32'h126, 32'h7FF0_0493, 1'b0, 1'b0};
    exp_tab[19] = '{32'h12A, 32'h0050_8093, 1'b1, 1'b0};
    exp_tab[20] = '{32'h160, 32'h0080_006F, 1'b1, 1'b0};
    exp_tab[21] = '{32'h162, 32'h0070_0193, 1'b1, 1'b0};
    exp_tab[22] = '{32'h164, 32'h00A0_0513, 1'b0, 1'b0};
  endtask

  ////////////////////////////////////////
  // Memory model and stimulus
  ////////////////////////////////////////

  // In-order responses, 1 to 4 cycles after acceptance
  task automatic serve_memory();
    mem_req_t req;
    // Busy while any accepted request still waits for its response
    assert (busy_o == (pending.size() != 0))
      else report_mismatch("busy_o", 32'(busy_o), 32'(pending.size() != 0));
    rsp_valid_i = 1'b0;
    if (pending.size() != 0 && pending[0].due <= cycles) begin
      req         = pending.pop_front();
      rsp_valid_i = 1'b1;
      rsp_rdata_i = mem_read(req.addr);
    end
    req_ready_i = (rand_next() % 3) != 0;
    // req_valid_o only moves on the rising edge
    if (req_valid_o && req_ready_i) begin
      pending.push_back('{req_addr_o, cycles + 32'd1 + rand_next() % 4});
    end
  endtask

  task automatic step();
    @(negedge clk);
    redirect_i.valid = 1'b0;
    serve_memory();
    id_ready_i = (rand_next() % 4) != 0;
  endtask

  task automatic apply_redirect(row_t row);
    redirect_i.valid   = 1'b1;
    redirect_i.pc_mux  = row.kind;
    redirect_i.irq_idx = row.irq_idx;
    case (row.kind)
      PC_BOOT: boot_addr_i   = row.target;
      PC_JUMP: jump_target_i = row.target;
      PC_MRET: mepc_i        = row.target;
      default: mtvec_i       = row.target[23:0];
    endcase
  endtask

  // Called on the edge before the handshake, if_id_o holds until then
  task automatic check_entry(exp_t e);
    logic [15:0] half;
    half = half_at(e.pc);
    assert (if_id_o.pc == e.pc)
      else report_mismatch("pc", if_id_o.pc, e.pc);
    assert (if_id_o.instr == e.instr)
      else report_mismatch("instr", if_id_o.instr, e.instr);
    assert (if_id_o.compressed_instr == half)
      else report_mismatch("compressed_instr", 32'(if_id_o.compressed_instr), 32'(half));
    assert (if_id_o.compressed == e.compressed)
      else report_mismatch("compressed", 32'(if_id_o.compressed), 32'(e.compressed));
    assert (if_id_o.illegal_c == e.illegal)
      else report_mismatch("illegal_c", 32'(if_id_o.illegal_c), 32'(e.illegal));
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 32'd1;
    if (cycles >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles, expected IF/ID entries never arrived",
                         cycles));
    end
  end

  initial begin
    int exp_idx;
    int got;
    rst_n         = 1'b0;
    redirect_i    = '0;
    boot_addr_i   = '0;
    jump_target_i = '0;
    mepc_i        = '0;
    mtvec_i       = '0;
    id_ready_i    = 1'b0;
    req_ready_i   = 1'b0;
    rsp_valid_i   = 1'b0;
    rsp_rdata_i   = '0;
    exp_idx       = 0;
    load_tables();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int r = 0; r < NUM_ROWS; r++) begin
      // Redirect lands while earlier fetches are still in flight
      step();
      apply_redirect(rows[r]);
      got = 0;
      while (got < int'(rows[r].count)) begin
        step();
        if (if_id_valid_o && id_ready_i) begin
          check_entry(exp_tab[exp_idx]);
          exp_idx++;
          got++;
        end
      end
    end

    $display("Everything OK");
    $finish;
  end

endmodule

//--- vlog.f
src/fetch_pkg.sv
src/fetch_c_decoder.sv
src/fetch_prefetcher.sv
src/fetch_word_fifo.sv
src/fetch_aligner.sv
src/fetch_stage.sv
testbench/fetch_chk.sv
testbench/tb_fetch_stage.sv

//--- Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_stage
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# Output is searched for the pass line, grep sets the exit status
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
